// File: hw/prefetch_params.svh
// Sizing constants for the instruction prefetch buffer
// PF_NUM_REQS may be 2 or 3; the queue depth follows from it
// PF_BOOT_ADDR must be word aligned

`ifndef PREFETCH_PARAMS_SVH
`define PREFETCH_PARAMS_SVH

// Granted requests that may still be waiting for a response
`define PF_NUM_REQS 2

// One entry more than the outstanding limit keeps the bus busy under back-pressure
`define PF_QUEUE_DEPTH (`PF_NUM_REQS + 1)

// Head address of the fetch queue out of reset
`define PF_BOOT_ADDR 32'h0000_0080

`endif

// File: hw/prefetch_pkg.sv
// Shared types of the prefetch buffer
// The queue count width follows PF_QUEUE_DEPTH so that a full queue is representable

`include "prefetch_params.svh"

package prefetch_pkg;

  ////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////

  // Byte address on both the core side and the memory side
  typedef logic [31:0] addr_t;

  // Raw 32-bit instruction word, no compressed realignment
  typedef logic [31:0] instr_t;

  // Fill level of the fetch queue, 0 up to PF_QUEUE_DEPTH
  typedef logic [$clog2(`PF_QUEUE_DEPTH + 1)-1:0] qcnt_t;

  ////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////

  // REQ_HOLD keeps an ungranted request on the bus
  // REQ_HOLD_DISCARD is the same, but a branch has already cancelled it
  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_HOLD,
    REQ_HOLD_DISCARD
  } req_state_e;

endpackage

// File: hw/fetch_req_fsm.sv
// Memory request FSM of the prefetch buffer
// An ungranted request stays on the bus unchanged until grant or protection error
// A protection error in the address cycle is treated as the grant

`timescale 1ns/100ps
`include "prefetch_params.svh"

module fetch_req_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic branch_i,
  input  logic branch_spec_i,
  input  logic instr_gnt_i,
  input  logic instr_pmp_err_i,
  input  logic space_i,
  input  logic full_i,
  input  logic empty_i,
  output logic instr_req_o,
  output logic issue_o,
  output logic hold_o,
  output logic accept_o,
  output logic accept_discard_o,
  output logic busy_o
);

  prefetch_pkg::req_state_e state_q, state_d;

  logic holding;
  logic branch_suppress;
  logic fresh_req;
  logic gnt_or_pmp_err;

  // Target on the bus is wrong when the branch is not taken
  assign branch_suppress = branch_spec_i & ~branch_i;

  assign holding = (state_q != prefetch_pkg::REQ_IDLE);

  // New request only with room for its response; a branch empties the queue anyway
  assign fresh_req = ~holding & req_i & ~branch_suppress &
                     (space_i | branch_i) & ~full_i;

  // Missing grant on a protection error is replaced here
  assign gnt_or_pmp_err = instr_gnt_i | instr_pmp_err_i;

  assign instr_req_o = holding | fresh_req;
  assign issue_o     = fresh_req;
  assign hold_o      = holding;
  assign accept_o    = instr_req_o & gnt_or_pmp_err;

  // Only a held request can be stale, a fresh one on a branch is the target itself
  assign accept_discard_o = accept_o & holding &
                            (branch_i | (state_q == prefetch_pkg::REQ_HOLD_DISCARD));

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      prefetch_pkg::REQ_IDLE: begin
        if (fresh_req && !gnt_or_pmp_err) begin
          state_d = prefetch_pkg::REQ_HOLD;
        end
      end
      prefetch_pkg::REQ_HOLD: begin
        if (gnt_or_pmp_err) begin
          state_d = prefetch_pkg::REQ_IDLE;
        end else if (branch_i) begin
          state_d = prefetch_pkg::REQ_HOLD_DISCARD;
        end
      end
      prefetch_pkg::REQ_HOLD_DISCARD: begin
        if (gnt_or_pmp_err) begin
          state_d = prefetch_pkg::REQ_IDLE;
        end
      end
      default: state_d = prefetch_pkg::REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= prefetch_pkg::REQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy while a request is on the bus or any response is still due
  assign busy_o = instr_req_o | ~empty_i;

endmodule

// File: hw/outstanding_tracker.sv
// Tracks granted requests whose response has not come back yet
// Entries form a thermometer, entry 0 is always the oldest request
// Responses are assumed in request order, one rvalid per request

`timescale 1ns/100ps
`include "prefetch_params.svh"

module outstanding_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic accept_i,
  input  logic accept_discard_i,
  input  logic pmp_err_i,
  input  logic rvalid_i,
  input  logic err_i,
  input  logic branch_i,
  output logic push_o,
  output logic push_err_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned NumReqs = `PF_NUM_REQS;

  logic [NumReqs-1:0] outst_q, outst_d;
  logic [NumReqs-1:0] discard_q, discard_d;
  logic [NumReqs-1:0] pmp_q, pmp_d;
  logic [NumReqs-1:0] fill;
  logic               rsp;

  // One-hot lowest free entry, taken by an accepted request
  assign fill = accept_i ? (~outst_q & {outst_q[NumReqs-2:0], 1'b1}) : '0;

  // A protection-errored head never sees rvalid, so it answers itself
  assign rsp = outst_q[0] & (rvalid_i | pmp_q[0]);

  ////////////////////////////////////////////////////////////
  // Entry update
  ////////////////////////////////////////////////////////////

  always_comb begin
    outst_d   = outst_q | fill;
    // Branch cancels everything already on its way back
    discard_d = discard_q | (outst_q & {NumReqs{branch_i}}) |
                (fill & {NumReqs{accept_discard_i}});
    pmp_d     = pmp_q | (fill & {NumReqs{pmp_err_i}});
    // Head answered, everything moves one step towards entry 0
    if (rsp) begin
      outst_d   = outst_d >> 1;
      discard_d = discard_d >> 1;
      pmp_d     = pmp_d >> 1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q   <= '0;
      discard_q <= '0;
      pmp_q     <= '0;
    end else begin
      outst_q   <= outst_d;
      discard_q <= discard_d;
      pmp_q     <= pmp_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Stale responses are swallowed here and never reach the queue
  assign push_o     = rsp & ~discard_q[0];
  assign push_err_o = err_i | pmp_q[0];

  assign full_o  = outst_q[NumReqs-1];
  assign empty_o = ~outst_q[0];

endmodule

// File: hw/fetch_addr_unit.sv
// Fetch address generation
// Registers start undefined; the core branches before its first fetch

`timescale 1ns/100ps
`include "prefetch_params.svh"

module fetch_addr_unit (
  input  logic                clk_i,
  input  logic                branch_i,
  input  logic                branch_spec_i,
  input  logic                issue_i,
  input  logic                hold_i,
  input  prefetch_pkg::addr_t addr_i,
  output prefetch_pkg::addr_t instr_addr_o
);

  prefetch_pkg::addr_t fetch_addr_q;
  prefetch_pkg::addr_t held_addr_q;
  prefetch_pkg::addr_t bus_addr;
  prefetch_pkg::addr_t fetch_base;

  // Next address to request, restarted by a branch
  assign fetch_base = branch_i ? addr_i : {fetch_addr_q[31:2], 2'b00};

  always_ff @(posedge clk_i) begin
    if (branch_i || issue_i) begin
      fetch_addr_q <= fetch_base + {29'd0, issue_i, 2'b00};
    end
  end

  // Address of the request just issued, used only if the grant does not come at once
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      held_addr_q <= bus_addr;
    end
  end

  // Held request first so the bus stays stable until granted
  assign bus_addr = hold_i                      ? held_addr_q :
                    (branch_spec_i | branch_i)  ? addr_i :
                                                  fetch_addr_q;

  assign instr_addr_o = {bus_addr[31:2], 2'b00};

endmodule

// File: hw/fetch_queue.sv
// Fetch queue between the memory responses and the core
// Entry 0 is the head; a pop shifts all entries down by one
// A push beyond the depth is prevented upstream by space_o

`timescale 1ns/100ps
`include "prefetch_params.svh"

module fetch_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 push_i,
  input  logic                 push_err_i,
  input  prefetch_pkg::instr_t push_rdata_i,
  input  prefetch_pkg::addr_t  branch_addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output logic                 space_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,
  output logic                 err_o
);

  localparam int unsigned Depth = `PF_QUEUE_DEPTH;

  prefetch_pkg::instr_t rdata_q [Depth];
  logic                 err_q   [Depth];
  prefetch_pkg::qcnt_t  count_q;
  prefetch_pkg::qcnt_t  wr_idx;
  prefetch_pkg::addr_t  head_addr_q;
  logic                 pop;

  assign valid_o = (count_q != '0);
  assign pop     = valid_o & ready_i;

  // Write slot after this cycle's pop has shifted the entries
  assign wr_idx = count_q - prefetch_pkg::qcnt_t'(pop);

  // Room for a response to every request that can still be issued
  assign space_o = (prefetch_pkg::qcnt_t'(Depth) - count_q) >=
                   prefetch_pkg::qcnt_t'(`PF_NUM_REQS);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < Depth; i++) begin : g_entry
    prefetch_pkg::instr_t up_rdata;
    logic                 up_err;

    // Value moving in from the entry above on a pop
    if (i == Depth - 1) begin : g_top
      assign up_rdata = rdata_q[i];
      assign up_err   = err_q[i];
    end else begin : g_mid
      assign up_rdata = rdata_q[i+1];
      assign up_err   = err_q[i+1];
    end

    always_ff @(posedge clk_i) begin
      if (push_i && (wr_idx == prefetch_pkg::qcnt_t'(i))) begin
        rdata_q[i] <= push_rdata_i;
        err_q[i]   <= push_err_i;
      end else if (pop) begin
        rdata_q[i] <= up_rdata;
        err_q[i]   <= up_err;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Fill level and head address
  ////////////////////////////////////////////////////////////

  // Clear wins over a push in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + prefetch_pkg::qcnt_t'(push_i) - prefetch_pkg::qcnt_t'(pop);
    end
  end

  // Head address is rebuilt from the branch target, one word per pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_addr_q <= `PF_BOOT_ADDR;
    end else if (clear_i) begin
      head_addr_q <= branch_addr_i;
    end else if (pop) begin
      head_addr_q <= head_addr_q + 32'd4;
    end
  end

  assign rdata_o = rdata_q[0];
  assign err_o   = err_q[0];
  assign addr_o  = head_addr_q;

endmodule

// File: hw/prefetch_buffer.sv
// Instruction prefetch buffer for a 32-bit in-order core
// Memory side is pipelined with grant and rvalid, responses in order
// Core pops with ready_i; any taken branch flushes the buffer

`timescale 1ns/100ps
`include "prefetch_params.svh"

module prefetch_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 branch_i,
  input  logic                 branch_spec_i,
  input  prefetch_pkg::addr_t  addr_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output prefetch_pkg::instr_t rdata_o,
  output prefetch_pkg::addr_t  addr_o,
  output logic                 err_o,
  // Memory side
  output logic                 instr_req_o,
  input  logic                 instr_gnt_i,
  output prefetch_pkg::addr_t  instr_addr_o,
  input  prefetch_pkg::instr_t instr_rdata_i,
  input  logic                 instr_err_i,
  input  logic                 instr_pmp_err_i,
  input  logic                 instr_rvalid_i,
  output logic                 busy_o
);

  logic space;
  logic full;
  logic empty;
  logic issue;
  logic hold;
  logic accept;
  logic accept_discard;
  logic push;
  logic push_err;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  fetch_req_fsm i_req_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .branch_i         (branch_i),
    .branch_spec_i    (branch_spec_i),
    .instr_gnt_i      (instr_gnt_i),
    .instr_pmp_err_i  (instr_pmp_err_i),
    .space_i          (space),
    .full_i           (full),
    .empty_i          (empty),
    .instr_req_o      (instr_req_o),
    .issue_o          (issue),
    .hold_o           (hold),
    .accept_o         (accept),
    .accept_discard_o (accept_discard),
    .busy_o           (busy_o)
  );

  fetch_addr_unit i_addr_unit (
    .clk_i         (clk_i),
    .branch_i      (branch_i),
    .branch_spec_i (branch_spec_i),
    .issue_i       (issue),
    .hold_i        (hold),
    .addr_i        (addr_i),
    .instr_addr_o  (instr_addr_o)
  );

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  outstanding_tracker i_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .accept_i         (accept),
    .accept_discard_i (accept_discard),
    .pmp_err_i        (instr_pmp_err_i),
    .rvalid_i         (instr_rvalid_i),
    .err_i            (instr_err_i),
    .branch_i         (branch_i),
    .push_o           (push),
    .push_err_o       (push_err),
    .full_o           (full),
    .empty_o          (empty)
  );

  // Branch target becomes the new head address of the queue
  fetch_queue i_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (branch_i),
    .push_i        (push),
    .push_err_i    (push_err),
    .push_rdata_i  (instr_rdata_i),
    .branch_addr_i (addr_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .space_o       (space),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .err_o         (err_o)
  );

endmodule

// File: verification/tb_clk_gen.sv
// Testbench clock and reset source
// 40 ns clock period, rst_no released 2 ns after the third rising edge

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod  = 20;
  localparam int unsigned ResetCycles = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release lines up with the stimulus offset of the testbench
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// File: verification/tb_prefetch_buffer.sv
// Testbench for the prefetch buffer with an in-order pipelined memory model
// Memory data is the address XOR 32'hA5A5_0000; 0x300-0x30F bus error, 0x400-0x40F PMP error
// Checks are assertions; a scoreboard tracks the expected head address

`timescale 1ns/100ps
`include "prefetch_params.svh"

module tb_prefetch_buffer;

  localparam int unsigned Seed = 32'hd4a09ab9;
  localparam logic [31:0] DataMask = 32'hA5A5_0000;
  // About 70 pops near 10 cycles each plus 70 fixed cycles fit well inside this limit
  localparam int unsigned TimeoutCycles = 4000;

  logic clk_i, rst_ni;
  logic req_i, branch_i, branch_spec_i, ready_i;
  prefetch_pkg::addr_t  addr_i, addr_o, instr_addr_o, exp_addr, exp_nxt, addr_seen, rsp_a;
  prefetch_pkg::addr_t  addr_prev;
  prefetch_pkg::instr_t rdata_o, instr_rdata_i;
  logic valid_o, err_o, busy_o;
  logic instr_req_o, instr_gnt_i, instr_err_i, instr_pmp_err_i, instr_rvalid_i;

  // Memory model and bookkeeping
  logic gnt_open, gnt_seen, acc_seen, req_seen;
  int unsigned gnt_wait, due_cyc, cyc, pop_count;
  int unsigned rsp_due [$];
  prefetch_pkg::addr_t rsp_addr [$];
  int errors, errs_at_start, tests_run, tests_failed;

  function automatic bit bus_err_range(input logic [31:0] a);
    return (a >= 32'h300) && (a <= 32'h30F);
  endfunction

  function automatic bit pmp_err_range(input logic [31:0] a);
    return (a >= 32'h400) && (a <= 32'h40F);
  endfunction

  tb_clk_gen i_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  prefetch_buffer i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (branch_i),
    .branch_spec_i   (branch_spec_i),
    .addr_i          (addr_i),
    .ready_i         (ready_i),
    .valid_o         (valid_o),
    .rdata_o         (rdata_o),
    .addr_o          (addr_o),
    .err_o           (err_o),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_addr_o    (instr_addr_o),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .instr_pmp_err_i (instr_pmp_err_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .busy_o          (busy_o)
  );

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  // PMP error comes back in the address cycle itself, in place of a grant
  assign instr_pmp_err_i = instr_req_o & pmp_err_range(instr_addr_o);
  assign instr_gnt_i     = instr_req_o & gnt_open & ~instr_pmp_err_i;

  // Mid-cycle sample of the bus once all inputs have settled
  always @(negedge clk_i) begin
    req_seen  = rst_ni && instr_req_o;
    gnt_seen  = req_seen && instr_gnt_i;
    acc_seen  = req_seen && (instr_gnt_i || instr_pmp_err_i);
    addr_prev = addr_seen;
    addr_seen = instr_addr_o;
  end

  always @(posedge clk_i) begin
    #2;
    // Response 1 to 3 cycles after grant and never ahead of an older one
    if (gnt_seen) begin
      due_cyc = cyc - 1 + $urandom_range(3, 1);
      if (rsp_due.size() > 0 && due_cyc <= rsp_due[$]) begin
        due_cyc = rsp_due[$] + 1;
      end
      rsp_due.push_back(due_cyc);
      rsp_addr.push_back(addr_seen);
    end
    // New grant delay of 0 to 2 cycles drawn per accepted request
    if (acc_seen) begin
      gnt_wait = $urandom_range(2, 0);
    end else if (req_seen && gnt_wait != 0) begin
      gnt_wait--;
    end
    gnt_open = (gnt_wait == 0);
    if (rsp_due.size() > 0 && rsp_due[0] == cyc) begin
      rsp_a = rsp_addr.pop_front();
      void'(rsp_due.pop_front());
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = rsp_a ^ DataMask;
      instr_err_i    = bus_err_range(rsp_a);
    end else begin
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard and timeout
  ////////////////////////////////////////////////////////////

  // Head address follows the last branch target and moves one word per pop
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (branch_i) begin
        exp_nxt = addr_i;
      end else if (valid_o && ready_i) begin
        exp_nxt = exp_nxt + 32'd4;
      end
      if (valid_o && ready_i) begin
        pop_count++;
      end
    end
  end

  // Applied just after the edge so each cycle sees its own head expectation
  always @(posedge clk_i) begin
    #1;
    exp_addr = exp_nxt;
  end

  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!valid_o && !instr_req_o && !busy_o))
    else begin
      errors++;
      $display("Error %0t: valid_o/instr_req_o/busy_o expected 000 got %b%b%b", $time,
               $sampled(valid_o), $sampled(instr_req_o), $sampled(busy_o));
    end

  a_pop_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && ready_i) |-> (addr_o == exp_addr))
    else begin
      errors++;
      $display("Error %0t: addr_o expected %h got %h", $time,
               $sampled(exp_addr), $sampled(addr_o));
    end

  // PMP-errored words carry no memory data
  a_pop_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && ready_i && !pmp_err_range(exp_addr)) |-> (rdata_o == (exp_addr ^ DataMask)))
    else begin
      errors++;
      $display("Error %0t: rdata_o expected %h got %h", $time,
               $sampled(exp_addr) ^ DataMask, $sampled(rdata_o));
    end

  a_pop_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && ready_i) |-> (err_o == (bus_err_range(exp_addr) || pmp_err_range(exp_addr))))
    else begin
      errors++;
      $display("Error %0t: err_o expected %b got %b", $time,
               bus_err_range($sampled(exp_addr)) || pmp_err_range($sampled(exp_addr)),
               $sampled(err_o));
    end

  a_hold_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i && !branch_i) |=>
    (valid_o && $stable(rdata_o) && $stable(addr_o) && $stable(err_o)))
    else begin
      errors++;
      $display("Error %0t: head entry changed while ready_i was low", $time);
    end

  a_bus_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i && !instr_pmp_err_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else begin
      errors++;
      $display("Error %0t: instr_addr_o expected %h got %h", $time,
               addr_prev, $sampled(instr_addr_o));
    end

  // Not-taken speculative branch may only see a request already held
  a_spec_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (branch_spec_i && !branch_i && !$past(instr_req_o && !instr_gnt_i && !instr_pmp_err_i))
    |-> !instr_req_o)
    else begin
      errors++;
      $display("Error %0t: instr_req_o expected 0 got 1", $time);
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni) branch_i |=> !valid_o)
    else begin
      errors++;
      $display("Error %0t: valid_o expected 0 got 1", $time);
    end

  // A request on the bus always counts as busy
  a_busy_req: assert property (@(posedge clk_i) disable iff (!rst_ni) instr_req_o |-> busy_o)
    else begin
      errors++;
      $display("Error %0t: busy_o expected 1 got 0", $time);
    end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic take_branch(input prefetch_pkg::addr_t target, input logic spec);
    branch_i      = 1'b1;
    branch_spec_i = spec;
    addr_i        = target;
    next_cycle();
    branch_i      = 1'b0;
    branch_spec_i = 1'b0;
  endtask

  // Runs until n more words have left the queue
  task automatic pop_words(input int unsigned n, input logic random_ready);
    int unsigned target;
    target = pop_count + n;
    while (pop_count < target) begin
      ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      next_cycle();
    end
  endtask

  task automatic wait_not_busy(input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (busy_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    assert (!busy_o)
      else begin
        errors++;
        $display("busy_o did not drop within %0d cycles after req_i went low", limit);
      end
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("Test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: fail with %0d errors", tests_run, name, errors - errs_at_start);
    end
    errs_at_start = errors;
  endtask

  initial begin
    int unsigned i;
    void'($urandom(Seed));
    req_i = 1'b0;
    branch_i = 1'b0;
    branch_spec_i = 1'b0;
    addr_i = '0;
    ready_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    gnt_wait = 1;
    gnt_open = 1'b0;
    exp_nxt = `PF_BOOT_ADDR;
    @(posedge rst_ni);
    next_cycle();

    req_i   = 1'b1;
    ready_i = 1'b1;
    take_branch(`PF_BOOT_ADDR, 1'b0);
    pop_words(8, 1'b0);
    close_test("reset and boot fetch");

    take_branch(32'h0000_0200, 1'b0);
    pop_words(20, 1'b1);
    close_test("sequential fetch with random ready");

    // Wrong-path targets on the bus followed by one taken speculative branch
    for (i = 0; i < 30; i++) begin
      ready_i       = 1'($urandom_range(1, 0));
      branch_spec_i = ($urandom_range(2, 0) == 0);
      addr_i        = 32'h0000_1000 + (i << 2);
      next_cycle();
    end
    branch_spec_i = 1'b0;
    take_branch(32'h0000_0240, 1'b1);
    pop_words(8, 1'b1);
    close_test("bus stability and speculative branch");

    // Stall the core first so requests are in flight at the branch
    for (i = 0; i < 4; i++) begin
      ready_i = 1'b0;
      repeat ($urandom_range(4, 1)) next_cycle();
      take_branch(32'h0000_0500 + (i << 6), 1'b0);
      pop_words(3, 1'b1);
    end
    close_test("branch flush with outstanding requests");

    take_branch(32'h0000_02F8, 1'b0);
    pop_words(10, 1'b1);
    take_branch(32'h0000_03F4, 1'b0);
    pop_words(10, 1'b1);
    close_test("bus and protection errors");

    req_i   = 1'b0;
    ready_i = 1'b1;
    wait_not_busy(40);
    close_test("busy drops when idle");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/prefetch_pkg.sv
hw/fetch_req_fsm.sv
hw/outstanding_tracker.sv
hw/fetch_addr_unit.sv
hw/fetch_queue.sv
hw/prefetch_buffer.sv
verification/tb_clk_gen.sv
verification/tb_prefetch_buffer.sv

// File: Bender.yml
package:
  name: prefetch_buffer

sources:
  - include_dirs:
      - hw
    files:
      - hw/prefetch_pkg.sv
      - hw/fetch_req_fsm.sv
      - hw/outstanding_tracker.sv
      - hw/fetch_addr_unit.sv
      - hw/fetch_queue.sv
      - hw/prefetch_buffer.sv
      - verification/tb_clk_gen.sv
      - verification/tb_prefetch_buffer.sv
